/* flist.f */
src/mem_types_pkg.sv
src/lsq_cfg_pkg.sv
src/mem_port_if.sv
src/store_queue.sv
src/load_queue.sv
src/mem_arbiter.sv
src/data_mem.sv
src/lsq_mem_top.sv
testbench/tb_clock_gen.sv
testbench/lsq_assertions.sv
testbench/lsq_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the load/store unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module lsq_tb \
    -Mdir obj_dir -o Vlsq_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# keep running past the first assertion error so the testbench can report
./obj_dir/Vlsq_tb +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "sim passed" sim.log; then
    exit 0
fi
exit 1

/* src/data_mem.sv */
module data_mem
    import mem_types_pkg::*;
(
    input  logic  clock,
    input  logic  mem_en,
    input  logic  mem_we,
    input  addr_t mem_addr,
    input  word_t mem_wdata,
    output word_t mem_rdata
);

    word_t mem [mem_depth];

    // power-up contents are zero
    initial begin
        for (int i = 0; i < mem_depth; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clock) begin
        if (mem_en) begin
            if (mem_we) begin
                mem[mem_addr] <= mem_wdata;
            end else begin
                mem_rdata <= mem[mem_addr];
            end
        end
    end

endmodule

/* src/load_queue.sv */
module load_queue
    import mem_types_pkg::*;
    import lsq_cfg_pkg::*;
(
    input  logic                clock,
    input  logic                rst_n,
    input  logic                squash,
    input  logic                ld_valid,
    input  addr_t               ld_addr,
    input  logic [tag_w-1:0]    ld_tag,
    mem_port_if.requester       mem,
    output addr_t               fwd_addr,
    output logic [sq_idx_w-1:0] fwd_mark,
    input  logic [sq_idx_w-1:0] sq_tail_mark,
    input  logic                fwd_hit,
    input  word_t               fwd_data,
    output logic                lq_full,
    output logic                ld_done,
    output logic [tag_w-1:0]    ld_tag_out,
    output word_t               ld_data
);

    lq_entry_t           entries [lq_size];
    logic [lq_idx_w-1:0] alloc_idx;
    logic [lq_idx_w-1:0] wait_idx;
    logic [lq_idx_w-1:0] done_idx;
    logic [lq_idx_w-1:0] lk_idx;
    logic [lq_idx_w-1:0] rd_idx;
    logic [sq_idx_w-1:0] lk_mark;
    logic                any_free;
    logic                any_wait;
    logic                any_done;
    logic                lk_valid;
    logic                rq_valid;
    logic                rd_busy;
    logic                accept;
    logic                pick;

    // lowest index wins in each search
    always_comb begin
        alloc_idx = '0;
        wait_idx  = '0;
        done_idx  = '0;
        any_free  = 1'b0;
        any_wait  = 1'b0;
        any_done  = 1'b0;
        for (int i = lq_size - 1; i >= 0; i--) begin
            if (!entries[i].valid) begin
                alloc_idx = lq_idx_w'(i);
                any_free  = 1'b1;
            end
            if (entries[i].waiting_mem) begin
                wait_idx = lq_idx_w'(i);
                any_wait = 1'b1;
            end
            if (entries[i].done) begin
                done_idx = lq_idx_w'(i);
                any_done = 1'b1;
            end
        end
    end

    assign lq_full = !any_free;
    assign accept  = ld_valid && any_free && !squash;

    // one read outstanding at a time
    assign pick = any_wait && !rq_valid && !rd_busy;

    assign fwd_addr = entries[lk_idx].addr;
    assign fwd_mark = lk_mark;

    assign mem.req   = rq_valid;
    assign mem.we    = 1'b0;
    assign mem.addr  = entries[rd_idx].addr;
    assign mem.wdata = '0;

    assign ld_done    = any_done;
    assign ld_tag_out = entries[done_idx].tag;
    assign ld_data    = entries[done_idx].data;

    always_ff @(posedge clock) begin
        if (!rst_n || squash) begin
            lk_valid <= 1'b0;
            rq_valid <= 1'b0;
            rd_busy  <= 1'b0;
            for (int i = 0; i < lq_size; i++) begin
                entries[i].valid       <= 1'b0;
                entries[i].waiting_mem <= 1'b0;
                entries[i].done        <= 1'b0;
            end
        end else begin
            if (accept) begin
                entries[alloc_idx].valid       <= 1'b1;
                entries[alloc_idx].waiting_mem <= 1'b0;
                entries[alloc_idx].done        <= 1'b0;
                entries[alloc_idx].tag         <= ld_tag;
                entries[alloc_idx].addr        <= ld_addr;
                lk_idx                         <= alloc_idx;
                lk_mark                        <= sq_tail_mark;
            end
            lk_valid <= accept;

            // lookup against the store snapshot
            if (lk_valid) begin
                if (fwd_hit) begin
                    entries[lk_idx].data <= fwd_data;
                    entries[lk_idx].done <= 1'b1;
                end else begin
                    entries[lk_idx].waiting_mem <= 1'b1;
                end
            end

            if (pick) begin
                rq_valid <= 1'b1;
                rd_idx   <= wait_idx;
            end
            if (mem.gnt) begin
                rq_valid <= 1'b0;
                rd_busy  <= 1'b1;
            end
            if (mem.rdata_valid && rd_busy) begin
                entries[rd_idx].data        <= mem.rdata;
                entries[rd_idx].waiting_mem <= 1'b0;
                entries[rd_idx].done        <= 1'b1;
                rd_busy                     <= 1'b0;
            end

            // presented this cycle, free it
            if (any_done) begin
                entries[done_idx].valid <= 1'b0;
                entries[done_idx].done  <= 1'b0;
            end
        end
    end

endmodule

/* src/lsq_cfg_pkg.sv */
package lsq_cfg_pkg;

    import mem_types_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // queue sizing
    //////////////////////////////////////////////////////////////////////

    localparam int sq_size  = 8;
    localparam int sq_idx_w = 3;
    localparam int lq_size  = 4;
    localparam int lq_idx_w = 2;
    localparam int tag_w    = 4;

    // committed stores wait here until the memory write is granted
    typedef struct packed {
        logic  valid;
        logic  committed;
        addr_t addr;
        word_t data;
    } sq_entry_t;

    typedef struct packed {
        logic             valid;
        logic             waiting_mem;
        logic             done;
        logic [tag_w-1:0] tag;
        addr_t            addr;
        word_t            data;
    } lq_entry_t;

endpackage

/* src/lsq_mem_top.sv */
module lsq_mem_top
    import mem_types_pkg::*;
    import lsq_cfg_pkg::*;
(
    input  logic             clock,
    input  logic             rst_n,
    input  logic             squash,
    input  logic             st_valid,
    input  addr_t            st_addr,
    input  word_t            st_data,
    input  logic             st_commit,
    input  logic             ld_valid,
    input  addr_t            ld_addr,
    input  logic [tag_w-1:0] ld_tag,
    output logic             sq_full,
    output logic             sq_empty,
    output logic             lq_full,
    output logic             st_retired,
    output logic             ld_done,
    output logic [tag_w-1:0] ld_tag_out,
    output word_t            ld_data
);

    addr_t               fwd_addr;
    logic [sq_idx_w-1:0] fwd_mark;
    logic [sq_idx_w-1:0] sq_tail_mark;
    logic                fwd_hit;
    word_t               fwd_data;
    logic                mem_en;
    logic                mem_we;
    addr_t               mem_addr;
    word_t               mem_wdata;
    word_t               mem_rdata;

    mem_port_if sq_port ();
    mem_port_if lq_port ();

    store_queue u_sq (
        .clock        (clock),
        .rst_n        (rst_n),
        .squash       (squash),
        .st_valid     (st_valid),
        .st_addr      (st_addr),
        .st_data      (st_data),
        .st_commit    (st_commit),
        .mem          (sq_port.requester),
        .fwd_addr     (fwd_addr),
        .fwd_mark     (fwd_mark),
        .fwd_hit      (fwd_hit),
        .fwd_data     (fwd_data),
        .sq_tail_mark (sq_tail_mark),
        .sq_full      (sq_full),
        .sq_empty     (sq_empty),
        .st_retired   (st_retired)
    );

    load_queue u_lq (
        .clock        (clock),
        .rst_n        (rst_n),
        .squash       (squash),
        .ld_valid     (ld_valid),
        .ld_addr      (ld_addr),
        .ld_tag       (ld_tag),
        .mem          (lq_port.requester),
        .fwd_addr     (fwd_addr),
        .fwd_mark     (fwd_mark),
        .sq_tail_mark (sq_tail_mark),
        .fwd_hit      (fwd_hit),
        .fwd_data     (fwd_data),
        .lq_full      (lq_full),
        .ld_done      (ld_done),
        .ld_tag_out   (ld_tag_out),
        .ld_data      (ld_data)
    );

    mem_arbiter u_arb (
        .clock     (clock),
        .rst_n     (rst_n),
        .sq_port   (sq_port.arbiter),
        .lq_port   (lq_port.arbiter),
        .mem_en    (mem_en),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

    data_mem u_mem (
        .clock     (clock),
        .mem_en    (mem_en),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

endmodule

/* src/mem_arbiter.sv */
module mem_arbiter
    import mem_types_pkg::*;
(
    input  logic         clock,
    input  logic         rst_n,
    mem_port_if.arbiter  sq_port,
    mem_port_if.arbiter  lq_port,
    output logic         mem_en,
    output logic         mem_we,
    output addr_t        mem_addr,
    output word_t        mem_wdata,
    input  word_t        mem_rdata
);

    logic rd_pending;
    logic rd_to_lq;

    // store drains always win
    assign sq_port.gnt = sq_port.req;
    assign lq_port.gnt = lq_port.req && !sq_port.req;

    assign mem_en    = sq_port.req || lq_port.req;
    assign mem_we    = sq_port.req ? sq_port.we    : lq_port.we;
    assign mem_addr  = sq_port.req ? sq_port.addr  : lq_port.addr;
    assign mem_wdata = sq_port.req ? sq_port.wdata : lq_port.wdata;

    // read data returns one cycle after the grant
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            rd_pending <= 1'b0;
            rd_to_lq   <= 1'b0;
        end else begin
            rd_pending <= mem_en && !mem_we;
            rd_to_lq   <= lq_port.gnt;
        end
    end

    assign sq_port.rdata_valid = rd_pending && !rd_to_lq;
    assign lq_port.rdata_valid = rd_pending && rd_to_lq;
    assign sq_port.rdata       = mem_rdata;
    assign lq_port.rdata       = mem_rdata;

endmodule

/* src/mem_port_if.sv */
interface mem_port_if
    import mem_types_pkg::*;
();

    logic  req;
    logic  we;
    addr_t addr;
    word_t wdata;
    logic  gnt;
    logic  rdata_valid;
    word_t rdata;

    // requester holds req and its fields until gnt
    modport requester (
        output req, we, addr, wdata,
        input  gnt, rdata_valid, rdata
    );

    modport arbiter (
        input  req, we, addr, wdata,
        output gnt, rdata_valid, rdata
    );

endinterface

/* src/mem_types_pkg.sv */
package mem_types_pkg;

    //////////////////////////////////////////////////////////////////////
    // data memory geometry
    //////////////////////////////////////////////////////////////////////

    // one word per address, no byte lanes
    localparam int data_w    = 32;
    localparam int addr_w    = 8;

    // covers every word address
    localparam int mem_depth = 256;

    typedef logic [data_w-1:0] word_t;
    typedef logic [addr_w-1:0] addr_t;

endpackage

/* src/store_queue.sv */
module store_queue
    import mem_types_pkg::*;
    import lsq_cfg_pkg::*;
(
    input  logic                clock,
    input  logic                rst_n,
    input  logic                squash,
    input  logic                st_valid,
    input  addr_t               st_addr,
    input  word_t               st_data,
    input  logic                st_commit,
    mem_port_if.requester       mem,
    input  addr_t               fwd_addr,
    input  logic [sq_idx_w-1:0] fwd_mark,
    output logic                fwd_hit,
    output word_t               fwd_data,
    output logic [sq_idx_w-1:0] sq_tail_mark,
    output logic                sq_full,
    output logic                sq_empty,
    output logic                st_retired
);

    sq_entry_t           entries [sq_size];
    logic [sq_idx_w-1:0] head;
    logic [sq_idx_w-1:0] cmt;
    logic [sq_idx_w-1:0] tail;
    logic [sq_idx_w-1:0] cmt_nxt;
    logic [sq_idx_w:0]   count;
    logic [sq_idx_w:0]   count_nxt;
    logic [sq_idx_w:0]   kill_cnt;
    logic [sq_size-1:0]  kill;
    logic                enq;
    logic                do_commit;
    logic                drain;

    assign sq_full   = (count == (sq_idx_w+1)'(sq_size));
    assign sq_empty  = (count == '0);
    assign enq       = st_valid && !sq_full && !squash;
    assign do_commit = st_commit && entries[cmt].valid && !entries[cmt].committed;
    assign cmt_nxt   = do_commit ? cmt + 1'b1 : cmt;

    // a load in the same cycle sees this store as older
    assign sq_tail_mark = enq ? tail + 1'b1 : tail;

    //////////////////////////////////////////////////////////////////////
    // drain port, head entry only
    //////////////////////////////////////////////////////////////////////

    assign mem.req    = entries[head].valid && entries[head].committed;
    assign mem.we     = 1'b1;
    assign mem.addr   = entries[head].addr;
    assign mem.wdata  = entries[head].data;
    assign drain      = mem.req && mem.gnt;
    assign st_retired = drain;

    // uncommitted entries dropped by squash
    always_comb begin
        kill     = '0;
        kill_cnt = '0;
        for (int i = 0; i < sq_size; i++) begin
            kill[i] = entries[i].valid && !entries[i].committed
                      && !(do_commit && cmt == sq_idx_w'(i));
            if (kill[i]) begin
                kill_cnt = kill_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        count_nxt = count;
        if (drain) begin
            count_nxt = count_nxt - 1'b1;
        end
        if (squash) begin
            count_nxt = count_nxt - kill_cnt;
        end else if (enq) begin
            count_nxt = count_nxt + 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // forwarding search, youngest below the mark first
    //////////////////////////////////////////////////////////////////////

    always_comb begin : fwd_search
        logic                stop;
        logic [sq_idx_w-1:0] idx;
        stop     = 1'b0;
        idx      = '0;
        fwd_hit  = 1'b0;
        fwd_data = '0;
        for (int k = 1; k <= sq_size; k++) begin
            idx = fwd_mark - sq_idx_w'(k);
            if (!stop) begin
                if (entries[idx].valid && entries[idx].addr == fwd_addr) begin
                    fwd_hit  = 1'b1;
                    fwd_data = entries[idx].data;
                    stop     = 1'b1;
                end
                // head is the oldest store
                if (idx == head) begin
                    stop = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            head  <= '0;
            cmt   <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < sq_size; i++) begin
                entries[i].valid     <= 1'b0;
                entries[i].committed <= 1'b0;
            end
        end else begin
            if (drain) begin
                entries[head].valid     <= 1'b0;
                entries[head].committed <= 1'b0;
                head                    <= head + 1'b1;
            end
            if (do_commit) begin
                entries[cmt].committed <= 1'b1;
            end
            cmt <= cmt_nxt;
            if (squash) begin
                for (int i = 0; i < sq_size; i++) begin
                    if (kill[i]) begin
                        entries[i].valid <= 1'b0;
                    end
                end
                tail <= cmt_nxt;
            end else if (enq) begin
                entries[tail].valid     <= 1'b1;
                entries[tail].committed <= 1'b0;
                entries[tail].addr      <= st_addr;
                entries[tail].data      <= st_data;
                tail                    <= tail + 1'b1;
            end
            count <= count_nxt;
        end
    end

endmodule

/* testbench/lsq_assertions.sv */
module lsq_assertions (
    input logic clock,
    input logic rst_n,
    input logic st_valid,
    input logic sq_full,
    input logic sq_empty,
    input logic ld_valid,
    input logic lq_full,
    input logic ld_done,
    input logic st_retired
);

    int fail_count = 0;

    // core side has no back-pressure, it must watch the full flags
    store_not_when_full: assert property (@(posedge clock) disable iff (!rst_n)
        st_valid |-> !sq_full)
    else begin
        fail_count++;
        $error("st_valid asserted while the store queue is full");
    end

    load_not_when_full: assert property (@(posedge clock) disable iff (!rst_n)
        ld_valid |-> !lq_full)
    else begin
        fail_count++;
        $error("ld_valid asserted while the load queue is full");
    end

    quiet_after_reset: assert property (@(posedge clock)
        $rose(rst_n) |-> (!ld_done && !st_retired))
    else begin
        fail_count++;
        $error("ld_done or st_retired high in the first cycle after reset");
    end

    // a retire needs a store that was already queued
    retire_needs_store: assert property (@(posedge clock) disable iff (!rst_n)
        st_retired |-> !$past(sq_empty))
    else begin
        fail_count++;
        $error("st_retired fired while the store queue was empty");
    end

endmodule

bind lsq_mem_top lsq_assertions lsq_checks_i (
    .clock      (clock),
    .rst_n      (rst_n),
    .st_valid   (st_valid),
    .sq_full    (sq_full),
    .sq_empty   (sq_empty),
    .ld_valid   (ld_valid),
    .lq_full    (lq_full),
    .ld_done    (ld_done),
    .st_retired (st_retired)
);

/* testbench/lsq_tb.sv */
module lsq_tb
    import mem_types_pkg::*;
    import lsq_cfg_pkg::*;
();

    localparam int num_tags     = 2 ** tag_w;
    localparam int rand_ops     = 200;
    localparam int directed_ops = 64;
    // 20 cycles per operation plus slack for reset and final drains
    localparam int cycle_limit  = 20 * (rand_ops + directed_ops) + 500;

    logic             clock;
    logic             rst_n;
    logic             squash;
    logic             st_valid;
    addr_t            st_addr;
    word_t            st_data;
    logic             st_commit;
    logic             ld_valid;
    addr_t            ld_addr;
    logic [tag_w-1:0] ld_tag;
    logic             sq_full;
    logic             sq_empty;
    logic             lq_full;
    logic             st_retired;
    logic             ld_done;
    logic [tag_w-1:0] ld_tag_out;
    word_t            ld_data;

    // reference state
    word_t       model_mem [mem_depth];
    addr_t       pq_addr [$];
    word_t       pq_data [$];
    int          pq_seq [$];
    bit          tag_busy [num_tags];
    word_t       exp_data [num_tags];
    int          ld_seq [num_tags];
    string       tag_test [num_tags];
    string       test_name;
    int          next_tag      = 0;
    int          seq_ctr       = 0;
    int          commit_count  = 0;
    int          retired_count = 0;
    int          checks        = 0;
    int          errors        = 0;
    int          cycle_count   = 0;
    logic [31:0] rng_state;

    tb_clock_gen clk_gen_i (
        .clock (clock),
        .rst_n (rst_n)
    );

    lsq_mem_top dut_i (
        .clock      (clock),
        .rst_n      (rst_n),
        .squash     (squash),
        .st_valid   (st_valid),
        .st_addr    (st_addr),
        .st_data    (st_data),
        .st_commit  (st_commit),
        .ld_valid   (ld_valid),
        .ld_addr    (ld_addr),
        .ld_tag     (ld_tag),
        .sq_full    (sq_full),
        .sq_empty   (sq_empty),
        .lq_full    (lq_full),
        .st_retired (st_retired),
        .ld_done    (ld_done),
        .ld_tag_out (ld_tag_out),
        .ld_data    (ld_data)
    );

    //////////////////////////////////////////////////////////////////////
    // reference model and helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // youngest uncommitted store wins over committed memory
    function automatic word_t expected_load(input addr_t a);
        word_t v;
        v = model_mem[a];
        for (int i = 0; i < pq_addr.size(); i++) begin
            if (pq_addr[i] == a) begin
                v = pq_data[i];
            end
        end
        return v;
    endfunction

    function automatic int free_tag();
        for (int k = 0; k < num_tags; k++) begin
            if (!tag_busy[(next_tag + k) % num_tags]) begin
                return (next_tag + k) % num_tags;
            end
        end
        return -1;
    endfunction

    function automatic int loads_outstanding();
        int n;
        n = 0;
        for (int t = 0; t < num_tags; t++) begin
            if (tag_busy[t]) begin
                n++;
            end
        end
        return n;
    endfunction

    // committing a store younger than a pending load would change that load
    function automatic bit commit_safe();
        if (pq_seq.size() == 0) begin
            return 1'b0;
        end
        for (int t = 0; t < num_tags; t++) begin
            if (tag_busy[t] && ld_seq[t] < pq_seq[0]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic tick();
        @(posedge clock);
        #1;
    endtask

    // one cycle of core strobes where the store counts as older than the load
    task automatic issue(input bit do_st, input addr_t sa, input word_t sd,
                         input bit do_cm, input bit do_ld, input addr_t la);
        int t;
        while (do_ld && (lq_full || free_tag() < 0)) begin
            tick();
        end
        if (do_cm && pq_seq.size() > 0) begin
            model_mem[pq_addr[0]] = pq_data[0];
            void'(pq_addr.pop_front());
            void'(pq_data.pop_front());
            void'(pq_seq.pop_front());
            commit_count++;
            st_commit = 1'b1;
        end
        if (do_st) begin
            pq_addr.push_back(sa);
            pq_data.push_back(sd);
            pq_seq.push_back(seq_ctr);
            seq_ctr++;
            st_valid = 1'b1;
            st_addr  = sa;
            st_data  = sd;
        end
        if (do_ld) begin
            t           = free_tag();
            tag_busy[t] = 1'b1;
            exp_data[t] = expected_load(la);
            ld_seq[t]   = seq_ctr;
            tag_test[t] = test_name;
            seq_ctr++;
            next_tag    = (t + 1) % num_tags;
            ld_valid    = 1'b1;
            ld_addr     = la;
            ld_tag      = tag_w'(t);
        end
        tick();
        st_valid  = 1'b0;
        st_commit = 1'b0;
        ld_valid  = 1'b0;
    endtask

    task automatic wait_loads();
        while (loads_outstanding() > 0) begin
            tick();
        end
    endtask

    task automatic commit_all();
        wait_loads();
        while (pq_seq.size() > 0) begin
            issue(1'b0, '0, '0, 1'b1, 1'b0, '0);
        end
    endtask

    task automatic wait_drained();
        while (!sq_empty) begin
            tick();
        end
        check_value({test_name, " retire count"}, 32'(commit_count), 32'(retired_count));
    endtask

    task automatic squash_pulse();
        wait_loads();
        squash = 1'b1;
        pq_addr.delete();
        pq_data.delete();
        pq_seq.delete();
        tick();
        squash = 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // directed and random tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_forward();
        test_name = "fwd_before_commit";
        issue(1'b1, 8'h10, 32'hcafe_0010, 1'b0, 1'b0, '0);
        issue(1'b0, '0, '0, 1'b0, 1'b1, 8'h10);
        commit_all();
        wait_drained();
    endtask

    task automatic test_memory();
        test_name = "mem_value";
        issue(1'b0, '0, '0, 1'b0, 1'b1, 8'h20);
        issue(1'b0, '0, '0, 1'b0, 1'b1, 8'h10);
        wait_loads();
    endtask

    task automatic test_youngest();
        test_name = "youngest_store";
        issue(1'b1, 8'h11, 32'h1111_0001, 1'b0, 1'b0, '0);
        issue(1'b1, 8'h11, 32'h2222_0002, 1'b0, 1'b0, '0);
        issue(1'b0, '0, '0, 1'b0, 1'b1, 8'h11);
        // same-cycle store is older than the load
        issue(1'b1, 8'h12, 32'h3333_0003, 1'b0, 1'b1, 8'h12);
        commit_all();
        wait_drained();
    endtask

    task automatic test_younger_store();
        test_name = "younger_store";
        issue(1'b0, '0, '0, 1'b0, 1'b1, 8'h13);
        issue(1'b1, 8'h13, 32'h4444_0004, 1'b0, 1'b0, '0);
        commit_all();
        wait_drained();
        issue(1'b0, '0, '0, 1'b0, 1'b1, 8'h13);
        wait_loads();
    endtask

    task automatic test_squash();
        test_name = "squash";
        issue(1'b1, 8'h14, 32'h5555_0005, 1'b0, 1'b0, '0);
        issue(1'b1, 8'h14, 32'h6666_0006, 1'b1, 1'b0, '0);
        issue(1'b1, 8'h15, 32'h7777_0007, 1'b0, 1'b0, '0);
        squash_pulse();
        issue(1'b0, '0, '0, 1'b0, 1'b1, 8'h14);
        issue(1'b0, '0, '0, 1'b0, 1'b1, 8'h15);
        wait_loads();
        wait_drained();
    endtask

    task automatic test_fill();
        test_name = "fill_drain";
        for (int i = 0; i < sq_size; i++) begin
            issue(1'b1, addr_t'(48 + i), next_rand(), 1'b0, 1'b0, '0);
        end
        check_value("fill sq_full", 32'd1, 32'(sq_full));
        commit_all();
        wait_drained();
        for (int i = 0; i < sq_size; i++) begin
            issue(1'b0, '0, '0, 1'b0, 1'b1, addr_t'(48 + i));
        end
        wait_loads();
    endtask

    // mixed traffic over 16 addresses
    task automatic test_random();
        logic [31:0] r;
        bit          do_st;
        bit          do_cm;
        bit          do_ld;
        test_name = "random";
        for (int i = 0; i < rand_ops; i++) begin
            r     = next_rand();
            do_st = r[0] && !sq_full;
            do_ld = r[1];
            do_cm = r[2] && commit_safe();
            issue(do_st, addr_t'(r[11:8]), next_rand(), do_cm, do_ld, addr_t'(r[15:12]));
            if (i % 64 == 63) begin
                squash_pulse();
            end
        end
        commit_all();
        wait_drained();
    endtask

    //////////////////////////////////////////////////////////////////////
    // compare process and watchdog
    //////////////////////////////////////////////////////////////////////

    always @(negedge clock) begin
        if (rst_n) begin
            if (ld_done) begin
                if (!tag_busy[ld_tag_out]) begin
                    errors++;
                    $display("ld_done returned tag %0d, which has no load outstanding",
                             ld_tag_out);
                end else begin
                    check_value(tag_test[ld_tag_out], exp_data[ld_tag_out], ld_data);
                    tag_busy[ld_tag_out] = 1'b0;
                end
            end
            if (st_retired) begin
                retired_count++;
            end
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the run hung, no progress after %0d cycles", cycle_count);
            $display("sim failed");
            $finish;
        end
    end

    initial begin
        squash    = 1'b0;
        st_valid  = 1'b0;
        st_addr   = '0;
        st_data   = '0;
        st_commit = 1'b0;
        ld_valid  = 1'b0;
        ld_addr   = '0;
        ld_tag    = '0;
        rng_state = 32'h4e12ac89;
        for (int i = 0; i < mem_depth; i++) begin
            model_mem[i] = '0;
        end
        for (int t = 0; t < num_tags; t++) begin
            tag_busy[t] = 1'b0;
        end

        @(posedge clock);
        while (rst_n !== 1'b1) begin
            @(posedge clock);
        end
        #1;

        check_value("reset sq_empty", 32'd1, 32'(sq_empty));
        check_value("reset sq_full", 32'd0, 32'(sq_full));
        check_value("reset lq_full", 32'd0, 32'(lq_full));
        check_value("reset ld_done", 32'd0, 32'(ld_done));

        test_forward();
        test_memory();
        test_youngest();
        test_younger_store();
        test_squash();
        test_fill();
        test_random();
        wait_loads();
        tick();

        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, dut_i.lsq_checks_i.fail_count);
        if (errors == 0 && dut_i.lsq_checks_i.fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* testbench/tb_clock_gen.sv */
module tb_clock_gen (
    output logic clock,
    output logic rst_n
);

    // period of 4
    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // low across three rising edges
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clock);
        #1;
        rst_n = 1'b1;
    end

endmodule
